//--- Makefile
VERILATOR = verilator
VFLAGS = --timing --assert
BUILD_FLAGS = --binary -j 0 $(VFLAGS)
TOP = tb_tsp
RTL_TOP = tsp_top
FILELIST = build.f
OBJ_DIR = obj_dir
PASS_MSG = Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(BUILD_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+hdl
hdl/tsp_pkg.sv
hdl/packet_buf.sv
hdl/tsp_regs.sv
hdl/pid_monitor.sv
hdl/pid_replacer.sv
hdl/ts_merge.sv
hdl/tsp_top.sv
sim/tb_tsp.sv

//--- hdl/packet_buf.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsp_cfg.svh"

module packet_buf import tsp_pkg::*; (
	input  logic        clk,
	input  logic        byte_we,
	input  byte_idx_t   byte_addr,
	input  logic [7:0]  byte_wdata,
	output logic [7:0]  byte_rdata,
	input  logic        word_we,
	input  word_idx_t   word_addr,
	input  logic [31:0] word_wdata,
	output logic [31:0] word_rdata
);

	logic [7:0] mem [`TSP_PKT_LEN];
	byte_idx_t word_base;

	assign word_base = {word_addr, 2'b00};

	always_ff @(posedge clk) begin
		if (byte_we && byte_addr < byte_idx_t'(`TSP_PKT_LEN)) begin
			mem[byte_addr] <= byte_wdata;
		end
		// little-endian, byte 0 of the word in bits 7:0
		if (word_we && word_addr < word_idx_t'(`TSP_PKT_WORDS)) begin
			for (int i = 0; i < 4; i++) begin
				mem[word_base + byte_idx_t'(i)] <= word_wdata[8*i +: 8];
			end
		end
		byte_rdata <= mem[byte_addr];
		word_rdata <= {mem[word_base + 8'd3], mem[word_base + 8'd2],
			mem[word_base + 8'd1], mem[word_base]};
	end

endmodule

`default_nettype wire

//--- hdl/pid_monitor.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsp_cfg.svh"

module pid_monitor import tsp_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [7:0]  in_data,
	input  logic        in_valid,
	input  logic        in_sync,
	input  logic        arm_set,
	input  pid_t        pid,
	input  logic        status_clr,
	output logic        armed,
	output logic        captured,
	input  word_idx_t   word_addr,
	output logic [31:0] word_rdata
);

	localparam byte_idx_t last_pos = byte_idx_t'(`TSP_PKT_LEN - 1);

	byte_idx_t pos_q;
	byte_idx_t cur_pos;
	logic [7:0] hdr0;
	logic [4:0] hdr1;
	logic pid_ok;
	logic hit;

	assign cur_pos = in_sync ? '0 : pos_q + 8'd1;
	assign pid_ok = hdr0 == `TSP_SYNC_BYTE && {hdr1, in_data} == pid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pos_q <= last_pos;
			armed <= 1'b0;
			captured <= 1'b0;
			hit <= 1'b0;
		end else begin
			if (in_valid) begin
				pos_q <= cur_pos;
				// only a packet written from byte 0 on can count
				if (in_sync) begin
					hit <= armed;
				end else if (cur_pos == 8'd2) begin
					hit <= hit && pid_ok;
				end
			end
			if (status_clr) begin
				captured <= 1'b0;
			end
			if (in_valid && hit && cur_pos == last_pos) begin
				captured <= 1'b1;
				armed <= 1'b0;
				hit <= 1'b0;
			end
			if (arm_set) begin
				armed <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && cur_pos == 8'd0) hdr0 <= in_data;
		if (in_valid && cur_pos == 8'd1) hdr1 <= in_data[4:0];
	end

	// every packet lands in the buffer while armed, a miss gets overwritten
	packet_buf u_buf (
		.clk        (clk),
		.byte_we    (armed && in_valid),
		.byte_addr  (cur_pos),
		.byte_wdata (in_data),
		.byte_rdata (),
		.word_we    (1'b0),
		.word_addr  (word_addr),
		.word_wdata (32'd0),
		.word_rdata (word_rdata)
	);

	no_gap_in_packet: assert property (@(posedge clk) disable iff (!rst_n)
		(in_valid && cur_pos < last_pos) |=> in_valid);

endmodule

`default_nettype wire

//--- hdl/pid_replacer.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsp_cfg.svh"

module pid_replacer import tsp_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [7:0]  in_data,
	input  logic        in_valid,
	input  logic        in_sync,
	input  logic        en,
	input  pid_t        pid,
	input  logic        count_clr,
	output logic [15:0] count,
	input  logic        word_we,
	input  word_idx_t   word_addr,
	input  logic [31:0] word_wdata,
	output logic [31:0] word_rdata,
	output logic        rep_active,
	output logic [7:0]  rep_byte
);

	localparam byte_idx_t last_pos = byte_idx_t'(`TSP_PKT_LEN - 1);

	byte_idx_t pos_q;
	byte_idx_t cur_pos;
	logic [7:0] hdr0;
	logic [4:0] hdr1;
	logic match_now;
	byte_idx_t rep_left;

	assign cur_pos = in_sync ? '0 : pos_q + 8'd1;

	// PID byte 2 on the input while byte 0 sits in the merge stage
	assign match_now = en && in_valid && cur_pos == 8'd2 &&
		hdr0 == `TSP_SYNC_BYTE && {hdr1, in_data} == pid;
	assign rep_active = match_now || rep_left != '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pos_q <= last_pos;
			rep_left <= '0;
			count <= '0;
		end else begin
			if (in_valid) begin
				pos_q <= cur_pos;
			end
			if (match_now) begin
				rep_left <= last_pos;
			end else if (rep_left != '0) begin
				rep_left <= rep_left - 8'd1;
			end
			if (count_clr) begin
				count <= '0;
			end else if (match_now) begin
				count <= count + 16'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && cur_pos == 8'd0) hdr0 <= in_data;
		if (in_valid && cur_pos == 8'd1) hdr1 <= in_data[4:0];
	end

	// read runs one byte behind the input, so rep_byte matches the delayed slot
	packet_buf u_buf (
		.clk        (clk),
		.byte_we    (1'b0),
		.byte_addr  (pos_q),
		.byte_wdata (8'd0),
		.byte_rdata (rep_byte),
		.word_we    (word_we),
		.word_addr  (word_addr),
		.word_wdata (word_wdata),
		.word_rdata (word_rdata)
	);

endmodule

`default_nettype wire

//--- hdl/ts_merge.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsp_cfg.svh"

module ts_merge (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] in_data,
	input  logic       in_valid,
	input  logic       in_sync,
	input  logic       rep_active,
	input  logic [7:0] rep_byte,
	output logic [7:0] out_data,
	output logic       out_valid,
	output logic       out_sync
);

	localparam int stages = `TSP_DELAY;

	logic [7:0] dly_data [stages];
	logic [stages-1:0] dly_valid;
	logic [stages-1:0] dly_sync;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dly_valid <= '0;
			dly_sync <= '0;
		end else begin
			dly_valid <= {dly_valid[stages-2:0], in_valid};
			dly_sync <= {dly_sync[stages-2:0], in_sync};
		end
	end

	always_ff @(posedge clk) begin
		dly_data[0] <= in_data;
		for (int i = 1; i < stages - 1; i++) begin
			dly_data[i] <= dly_data[i-1];
		end
		// substitution on the way into the last stage
		dly_data[stages-1] <= rep_active ? rep_byte : dly_data[stages-2];
	end

	assign out_data = dly_data[stages-1];
	assign out_valid = dly_valid[stages-1];
	assign out_sync = dly_sync[stages-1];

	rep_on_valid_slot: assert property (@(posedge clk) disable iff (!rst_n)
		rep_active |-> dly_valid[stages-2]);

endmodule

`default_nettype wire

//--- hdl/tsp_cfg.svh
`ifndef TSP_CFG_SVH
`define TSP_CFG_SVH

// packet geometry
`define TSP_PKT_LEN 188
`define TSP_PKT_WORDS 47
`define TSP_SYNC_BYTE 8'h47

// input to output latency in clk cycles
`define TSP_DELAY 3

// buffer windows, in bus word addresses
`define TSP_MON_BASE 64
`define TSP_REP_BASE 128

`endif

//--- hdl/tsp_pkg.sv
`default_nettype none

package tsp_pkg;

	typedef logic [12:0] pid_t;

	// byte position inside a packet
	typedef logic [7:0] byte_idx_t;

	// word position inside a packet buffer
	typedef logic [5:0] word_idx_t;

	typedef enum logic [9:0] {
		REG_CTRL = 10'd0,
		REG_MON_PID = 10'd1,
		REG_REP_PID = 10'd2,
		REG_STATUS = 10'd3,
		REG_REP_COUNT = 10'd4
	} reg_addr_e;

endpackage

`default_nettype wire

//--- hdl/tsp_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsp_cfg.svh"

module tsp_regs import tsp_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [9:0]  adr,
	input  logic [3:0]  sel,
	input  logic [31:0] dat_w,
	output logic [31:0] dat_r,
	output logic        ack,
	output logic        mon_arm_set,
	output pid_t        mon_pid,
	output pid_t        rep_pid,
	output logic        rep_en,
	output logic        status_clr,
	output logic        count_clr,
	output word_idx_t   buf_word,
	output logic        rep_buf_we,
	output logic [31:0] buf_wdata,
	input  logic        mon_armed,
	input  logic        mon_captured,
	input  logic [15:0] rep_count,
	input  logic [31:0] mon_rdata,
	input  logic [31:0] rep_rdata
);

	logic req;
	logic wr;
	logic mon_win;
	logic rep_win;
	logic [31:0] reg_rdata;

	// first cycle of a bus access, ack follows one cycle later
	assign req = cyc && stb && !ack;
	assign wr = req && we;

	assign mon_win = adr >= 10'(`TSP_MON_BASE) && adr < 10'(`TSP_MON_BASE + `TSP_PKT_WORDS);
	assign rep_win = adr >= 10'(`TSP_REP_BASE) && adr < 10'(`TSP_REP_BASE + `TSP_PKT_WORDS);

	// both windows sit on 64-word boundaries
	assign buf_word = adr[5:0];
	assign buf_wdata = dat_w;
	assign rep_buf_we = wr && rep_win && (sel == 4'hf);

	assign mon_arm_set = wr && adr == REG_CTRL && sel[0] && dat_w[0];
	assign status_clr = wr && adr == REG_STATUS && sel[0] && dat_w[0];
	assign count_clr = wr && adr == REG_REP_COUNT;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack <= 1'b0;
			rep_en <= 1'b0;
			mon_pid <= '0;
			rep_pid <= '0;
		end else begin
			ack <= req;
			if (wr && adr == REG_CTRL && sel[0]) begin
				rep_en <= dat_w[1];
			end
			if (wr && adr == REG_MON_PID) begin
				if (sel[0]) mon_pid[7:0] <= dat_w[7:0];
				if (sel[1]) mon_pid[12:8] <= dat_w[12:8];
			end
			if (wr && adr == REG_REP_PID) begin
				if (sel[0]) rep_pid[7:0] <= dat_w[7:0];
				if (sel[1]) rep_pid[12:8] <= dat_w[12:8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req) begin
			case (adr)
				REG_CTRL: reg_rdata <= {30'd0, rep_en, mon_armed};
				REG_MON_PID: reg_rdata <= {19'd0, mon_pid};
				REG_REP_PID: reg_rdata <= {19'd0, rep_pid};
				REG_STATUS: reg_rdata <= {31'd0, mon_captured};
				REG_REP_COUNT: reg_rdata <= {16'd0, rep_count};
				default: reg_rdata <= '0;
			endcase
		end
	end

	// buffer words arrive one cycle after the address, together with ack
	assign dat_r = mon_win ? mon_rdata : (rep_win ? rep_rdata : reg_rdata);

	ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n)
		ack |-> (cyc && stb));

endmodule

`default_nettype wire

//--- hdl/tsp_top.sv
`timescale 1ns/1ps
`default_nettype none

module tsp_top import tsp_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [9:0]  adr,
	input  logic [3:0]  sel,
	input  logic [31:0] dat_w,
	output logic [31:0] dat_r,
	output logic        ack,
	input  logic [7:0]  in_data,
	input  logic        in_valid,
	input  logic        in_sync,
	output logic [7:0]  out_data,
	output logic        out_valid,
	output logic        out_sync
);

	logic mon_arm_set;
	pid_t mon_pid;
	pid_t rep_pid;
	logic rep_en;
	logic status_clr;
	logic count_clr;
	word_idx_t buf_word;
	logic rep_buf_we;
	logic [31:0] buf_wdata;
	logic mon_armed;
	logic mon_captured;
	logic [15:0] rep_count;
	logic [31:0] mon_rdata;
	logic [31:0] rep_rdata;
	logic rep_active;
	logic [7:0] rep_byte;

	tsp_regs u_regs (
		.clk, .rst_n, .cyc, .stb, .we, .adr, .sel, .dat_w, .dat_r, .ack,
		.mon_arm_set, .mon_pid, .rep_pid, .rep_en, .status_clr, .count_clr,
		.buf_word, .rep_buf_we, .buf_wdata,
		.mon_armed, .mon_captured, .rep_count, .mon_rdata, .rep_rdata
	);

	pid_monitor u_monitor (
		.clk, .rst_n, .in_data, .in_valid, .in_sync,
		.arm_set    (mon_arm_set),
		.pid        (mon_pid),
		.status_clr (status_clr),
		.armed      (mon_armed),
		.captured   (mon_captured),
		.word_addr  (buf_word),
		.word_rdata (mon_rdata)
	);

	pid_replacer u_replacer (
		.clk, .rst_n, .in_data, .in_valid, .in_sync,
		.en         (rep_en),
		.pid        (rep_pid),
		.count_clr  (count_clr),
		.count      (rep_count),
		.word_we    (rep_buf_we),
		.word_addr  (buf_word),
		.word_wdata (buf_wdata),
		.word_rdata (rep_rdata),
		.rep_active (rep_active),
		.rep_byte   (rep_byte)
	);

	ts_merge u_merge (
		.clk, .rst_n, .in_data, .in_valid, .in_sync,
		.rep_active, .rep_byte, .out_data, .out_valid, .out_sync
	);

endmodule

`default_nettype wire

//--- sim/tb_tsp.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsp_cfg.svh"

module tb_tsp;

	localparam int max_recs = 64;
	localparam int max_pkts = 16;
	localparam int bus_timeout = 20;
	localparam int drain_timeout = 2000;

	logic clk;
	logic rst_n;
	logic cyc;
	logic stb;
	logic we;
	logic [9:0] adr;
	logic [3:0] sel;
	logic [31:0] dat_w;
	logic [31:0] dat_r;
	logic ack;
	logic [7:0] in_data;
	logic in_valid;
	logic in_sync;
	logic [7:0] out_data;
	logic out_valid;
	logic out_sync;

	logic [55:0] recs [max_recs];
	logic [7:0] sent [max_pkts][`TSP_PKT_LEN];
	logic [7:0] rep_pkt [`TSP_PKT_LEN];
	logic [7:0] exp_data [$];
	logic exp_sync [$];
	int unsigned exp_stamp [$];
	logic [31:0] lcg_state;
	int unsigned cycle = 0;
	int n_sent;
	int n_checks;
	int n_errors;
	int n_timeouts;

	tsp_top u_tsp_top (
		.clk, .rst_n, .cyc, .stb, .we, .adr, .sel, .dat_w, .dat_r, .ack,
		.in_data, .in_valid, .in_sync, .out_data, .out_valid, .out_sync
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// one Wishbone classic cycle, returns when ack has been seen
	task automatic bus_access(input logic write, input logic [9:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= write;
		adr <= addr;
		sel <= 4'hf;
		dat_w <= wdata;
		in_valid <= 1'b0;
		in_sync <= 1'b0;
		@(posedge clk);
		while (!ack && waited < bus_timeout) begin
			waited++;
			@(posedge clk);
		end
		rdata = dat_r;
		if (!ack) begin
			n_timeouts++;
			$display("bus access to address 0x%03h was never acknowledged", addr);
		end
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic send_packet(input logic [12:0] pid, input logic replaced, input int gap);
		int idx;
		idx = n_sent;
		sent[idx][0] = `TSP_SYNC_BYTE;
		lcg_state = lcg_next(lcg_state);
		// flag bits above the PID are random too
		sent[idx][1] = {lcg_state[23:21], pid[12:8]};
		sent[idx][2] = pid[7:0];
		for (int i = 3; i < `TSP_PKT_LEN; i++) begin
			lcg_state = lcg_next(lcg_state);
			sent[idx][i] = lcg_state[23:16];
		end
		for (int i = 0; i < `TSP_PKT_LEN; i++) begin
			@(posedge clk);
			in_data <= sent[idx][i];
			in_valid <= 1'b1;
			in_sync <= (i == 0);
			exp_data.push_back(replaced ? rep_pkt[i] : sent[idx][i]);
			exp_sync.push_back(i == 0);
			// the DUT samples the byte one edge after it is driven
			exp_stamp.push_back(cycle + `TSP_DELAY + 1);
		end
		n_sent++;
		if (gap > 0) begin
			@(posedge clk);
			in_valid <= 1'b0;
			in_sync <= 1'b0;
			repeat (gap - 1) @(posedge clk);
		end
	endtask

	task automatic load_replacement(input logic [12:0] pid);
		logic [31:0] word;
		logic [31:0] rd;
		rep_pkt[0] = `TSP_SYNC_BYTE;
		rep_pkt[1] = {3'b000, pid[12:8]};
		rep_pkt[2] = pid[7:0];
		for (int i = 3; i < `TSP_PKT_LEN; i++) begin
			lcg_state = lcg_next(lcg_state);
			rep_pkt[i] = lcg_state[23:16];
		end
		// four bytes per word, lowest byte first
		for (int w = 0; w < `TSP_PKT_WORDS; w++) begin
			word = {rep_pkt[4*w+3], rep_pkt[4*w+2], rep_pkt[4*w+1], rep_pkt[4*w]};
			bus_access(1'b1, 10'(`TSP_REP_BASE + w), word, rd);
		end
		for (int w = 0; w < `TSP_PKT_WORDS; w++) begin
			word = {rep_pkt[4*w+3], rep_pkt[4*w+2], rep_pkt[4*w+1], rep_pkt[4*w]};
			bus_access(1'b0, 10'(`TSP_REP_BASE + w), 32'd0, rd);
			n_checks++;
			if (rd !== word) begin
				n_errors++;
				$display("[FAIL] replacer word %0d: expected %h, actual %h", w, word, rd);
			end
		end
	endtask

	task automatic check_monitor(input int idx);
		logic [31:0] word;
		logic [31:0] rd;
		for (int w = 0; w < `TSP_PKT_WORDS; w++) begin
			word = {sent[idx][4*w+3], sent[idx][4*w+2], sent[idx][4*w+1], sent[idx][4*w]};
			bus_access(1'b0, 10'(`TSP_MON_BASE + w), 32'd0, rd);
			n_checks++;
			if (rd !== word) begin
				n_errors++;
				$display("[FAIL] monitor word %0d of packet %0d: expected %h, actual %h",
					w, idx, word, rd);
			end
		end
	endtask

	task automatic drain_output();
		int waited;
		waited = 0;
		@(posedge clk);
		in_valid <= 1'b0;
		in_sync <= 1'b0;
		while (exp_data.size() > 0 && waited < drain_timeout) begin
			waited++;
			@(negedge clk);
		end
		if (exp_data.size() > 0) begin
			n_timeouts++;
			$display("output stream still owes %0d bytes", exp_data.size());
		end
	endtask

	// output checker, every byte at its expected cycle
	always @(posedge clk) begin
		if (rst_n) begin
			if (out_valid) begin
				if (exp_data.size() == 0) begin
					n_errors++;
					$display("output byte %h arrived while no byte was expected", out_data);
				end else begin
					n_checks++;
					if (out_data !== exp_data[0]) begin
						n_errors++;
						$display("[FAIL] output data: expected %h, actual %h",
							exp_data[0], out_data);
					end
					if (out_sync !== exp_sync[0]) begin
						n_errors++;
						$display("[FAIL] output sync: expected %b, actual %b",
							exp_sync[0], out_sync);
					end
					if (cycle != exp_stamp[0]) begin
						n_errors++;
						$display("[FAIL] output timing: expected cycle %0d, actual cycle %0d",
							exp_stamp[0], cycle);
					end
					void'(exp_data.pop_front());
					void'(exp_sync.pop_front());
					void'(exp_stamp.pop_front());
				end
			end else if (exp_data.size() > 0 && exp_stamp[0] <= cycle) begin
				n_errors++;
				$display("output byte %h missing at cycle %0d", exp_data[0], cycle);
				void'(exp_data.pop_front());
				void'(exp_sync.pop_front());
				void'(exp_stamp.pop_front());
			end
		end
	end

	initial begin
		logic [7:0] op;
		logic [15:0] arg;
		logic [31:0] val;
		logic [31:0] rd;
		rst_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		sel = '0;
		dat_w = '0;
		in_data = '0;
		in_valid = 1'b0;
		in_sync = 1'b0;
		lcg_state = 32'h3733a3aa;
		n_sent = 0;
		n_checks = 0;
		n_errors = 0;
		n_timeouts = 0;
		for (int i = 0; i < max_recs; i++) begin
			recs[i] = '0;
		end
		$readmemh("sim/tsp_input.hex", recs);
		if (recs[0][55:48] == 8'h00) begin
			n_errors++;
			$display("no stimulus records were loaded from sim/tsp_input.hex");
		end
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		@(posedge clk);
		n_checks++;
		if (out_valid !== 1'b0) begin
			n_errors++;
			$display("[FAIL] reset out_valid: expected 0, actual %b", out_valid);
		end
		if (ack !== 1'b0) begin
			n_errors++;
			$display("[FAIL] reset ack: expected 0, actual %b", ack);
		end
		for (int r = 0; r < max_recs; r++) begin
			op = recs[r][55:48];
			arg = recs[r][47:32];
			val = recs[r][31:0];
			if (op == 8'h00 || n_timeouts > 0) break;
			case (op)
				8'h01: bus_access(1'b1, arg[9:0], val, rd);
				8'h02: begin
					bus_access(1'b0, arg[9:0], 32'd0, rd);
					n_checks++;
					if (rd !== val) begin
						n_errors++;
						$display("[FAIL] read 0x%03h in record %0d: expected %h, actual %h",
							arg[9:0], r, val, rd);
					end
				end
				8'h03: send_packet(arg[12:0], 1'b0, int'(val));
				8'h04: send_packet(arg[12:0], 1'b1, int'(val));
				8'h05: load_replacement(arg[12:0]);
				8'h06: check_monitor(int'(arg));
				8'h07: drain_output();
				default: begin
					n_errors++;
					$display("record %0d has unknown opcode %h", r, op);
				end
			endcase
		end
		if (n_timeouts == 0) begin
			drain_output();
		end
		$display("summary: %0d checks, %0d errors, %0d timeouts", n_checks, n_errors, n_timeouts);
		if (n_errors == 0 && n_timeouts == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/tsp_input.hex
// record = op_arg_value; op 01 bus write, 02 bus read and compare, 03 send passthrough packet,
// 04 send replaced packet, 05 load replacer buffer, 06 compare monitor buffer, 07 drain, 00 end
// arg is a word address, a PID or a sent packet index; value is data, expected data or idle cycles
02_0000_00000000
02_0003_00000000
02_0004_00000000
01_0001_0000fabc
02_0001_00001abc
01_0002_00000123
02_0002_00000123
02_0005_00000000
02_006f_00000000
02_03ff_00000000
03_0100_00000000
03_0200_00000005
03_0300_00000000
03_0123_00000003
07_0000_00000000
05_0123_00000000
01_0000_00000002
02_0000_00000002
04_0123_00000000
03_0400_00000000
04_0123_00000002
07_0000_00000000
02_0004_00000002
01_0004_00000000
02_0004_00000000
01_0000_00000003
02_0000_00000003
03_0500_00000002
03_1abc_00000002
02_0003_00000001
02_0000_00000002
06_0008_00000000
03_1abc_00000002
06_0008_00000000
01_0003_00000001
02_0003_00000000
01_0001_00000123
01_0000_00000003
04_0123_00000002
07_0000_00000000
06_000a_00000000
02_0003_00000001
02_0004_00000001
00_0000_00000000
